//--- flist.f
rtl/erx_pkg.sv
rtl/erx_fifo.sv
rtl/erx_mmu.sv
rtl/erx_arbiter.sv
rtl/erx_timeout.sv
rtl/erx_core.sv
tests/tb_clock.sv
tests/tb_erx_core.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f flist.f --top-module tb_erx_core \
  -Mdir obj_dir -o tb_erx_core

out=$(./obj_dir/tb_erx_core || true)
echo "$out"

if echo "$out" | grep -qx "Test passed"; then
  exit 0
else
  exit 1
fi

//--- tests/tb_erx_core.sv
`default_nettype none

module tb_erx_core
  import erx_pkg::*;
;

  localparam link_id_t link_id = 12'h800;

  logic clk, reset;
  logic erx_access, edma_access, ecfg_access;
  packet_t erx_packet, edma_packet, ecfg_packet;
  logic rx_rd_wait, rx_wr_wait, edma_wait, ecfg_wait;
  logic mmu_enable, mmu_cfg_write;
  mmu_index_t mmu_cfg_index;
  link_id_t mmu_cfg_value;
  logic rxwr_access, rxrd_access, rxrr_access;
  packet_t rxwr_packet, rxrd_packet, rxrr_packet;
  logic rxwr_wait, rxrd_wait, rxrr_wait;

  // Model state
  packet_t exp_wr[$];
  packet_t exp_rd[$];
  packet_t exp_rr[$];
  packet_t wr_head, rd_head, rr_head;
  logic wr_have, rd_have, rr_have;
  link_id_t tbl [16];
  logic [31:0] lfsr = 32'hf86c8011;
  logic hold = 1'b0;
  int errors = 0;
  int timeouts = 0;

  tb_clock i_clock (.clk(clk), .reset(reset));

  erx_core #(.link_id(link_id), .fifo_depth(4), .timeout_cycles(64)) i_dut (
    .clk(clk), .reset(reset),
    .erx_access(erx_access), .erx_packet(erx_packet),
    .rx_rd_wait(rx_rd_wait), .rx_wr_wait(rx_wr_wait),
    .edma_access(edma_access), .edma_packet(edma_packet), .edma_wait(edma_wait),
    .ecfg_access(ecfg_access), .ecfg_packet(ecfg_packet), .ecfg_wait(ecfg_wait),
    .mmu_enable(mmu_enable), .mmu_cfg_write(mmu_cfg_write),
    .mmu_cfg_index(mmu_cfg_index), .mmu_cfg_value(mmu_cfg_value),
    .rxwr_access(rxwr_access), .rxwr_packet(rxwr_packet), .rxwr_wait(rxwr_wait),
    .rxrd_access(rxrd_access), .rxrd_packet(rxrd_packet), .rxrd_wait(rxrd_wait),
    .rxrr_access(rxrr_access), .rxrr_packet(rxrr_packet), .rxrr_wait(rxrr_wait)
  );

  // ##############################
  // Random numbers
  // ##############################

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // One step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // Bit 31 clear keeps it away from our own id
  function automatic addr_t rand_addr();
    logic [31:0] r;
    r = rand_bits(31);
    return {1'b0, r[30:0]};
  endfunction

  // Datamode 01, random data and source
  function automatic packet_t make_packet(input logic write, input addr_t dst);
    return {rand_bits(32), rand_bits(32), dst, 7'b0000001, write};
  endfunction

  // ##############################
  // Reference model
  // ##############################

  task automatic refresh_heads();
    wr_have = (exp_wr.size() != 0);
    rd_have = (exp_rd.size() != 0);
    rr_have = (exp_rr.size() != 0);
    wr_head = wr_have ? exp_wr[0] : '0;
    rd_head = rd_have ? exp_rd[0] : '0;
    rr_head = rr_have ? exp_rr[0] : '0;
  endtask

  // Route a link packet the way the block should
  task automatic predict_link(input packet_t p);
    addr_t dst;
    dst = pkt_dstaddr(p);
    if (pkt_write(p) && dst[31:20] == link_id && dst[19:16] == 4'hD) begin
      exp_rr.push_back(p);
    end else begin
      if (mmu_enable) begin
        p = pkt_set_dstaddr(p, {tbl[dst[31:28]], dst[19:0]});
      end
      if (pkt_write(p)) begin
        exp_wr.push_back(p);
      end else begin
        exp_rd.push_back(p);
      end
    end
    refresh_heads();
  endtask

  task automatic push_rd(input packet_t p);
    exp_rd.push_back(p);
    refresh_heads();
  endtask

  task automatic push_rr(input packet_t p);
    exp_rr.push_back(p);
    refresh_heads();
  endtask

  // Retire what the DUT hands over
  always @(posedge clk) begin
    if (!reset) begin
      if (rxwr_access && !rxwr_wait && wr_have) exp_wr.delete(0);
      if (rxrd_access && !rxrd_wait && rd_have) exp_rd.delete(0);
      if (rxrr_access && !rxrr_wait && rr_have) exp_rr.delete(0);
      refresh_heads();
    end
  end

  // Random output stalls, forced during back-pressure
  always @(posedge clk) begin
    #5;
    if (reset) begin
      rxwr_wait = 1'b0;
      rxrd_wait = 1'b0;
      rxrr_wait = 1'b0;
    end else begin
      rxwr_wait = hold | (rand_bits(2) == 32'd3);
      rxrd_wait = rand_bits(2) == 32'd3;
      rxrr_wait = hold | (rand_bits(2) == 32'd3);
    end
  end

  // ##############################
  // Checks
  // ##############################

  // Sampled mid cycle, where every input is settled
  a_wr: assert property (@(negedge clk) disable iff (reset)
    rxwr_access && !rxwr_wait |-> wr_have && rxwr_packet == wr_head)
    else begin
      errors = errors + 1;
      $display("FAILED %0t: rxwr packet %h, expected %h", $time, rxwr_packet, wr_head);
    end

  a_rd: assert property (@(negedge clk) disable iff (reset)
    rxrd_access && !rxrd_wait |-> rd_have && rxrd_packet == rd_head)
    else begin
      errors = errors + 1;
      $display("FAILED %0t: rxrd packet %h, expected %h", $time, rxrd_packet, rd_head);
    end

  a_rr: assert property (@(negedge clk) disable iff (reset)
    rxrr_access && !rxrr_wait |-> rr_have && rxrr_packet == rr_head)
    else begin
      errors = errors + 1;
      $display("FAILED %0t: rxrr packet %h, expected %h", $time, rxrr_packet, rr_head);
    end

  // ##############################
  // Drivers
  // ##############################

  // Hold one transfer until the wait drops
  task automatic send_link(input packet_t p);
    int n;
    logic done;
    erx_access = 1'b1;
    erx_packet = p;
    done = 1'b0;
    n = 0;
    while (!done && n < 200) begin
      @(negedge clk);
      done = !rx_wr_wait;
      @(posedge clk);
      #5;
      n++;
    end
    erx_access = 1'b0;
    if (!done) begin
      timeouts++;
      $display("timed out waiting for the link packet to be accepted");
    end
  endtask

  task automatic send_dma(input packet_t p);
    int n;
    logic done;
    edma_access = 1'b1;
    edma_packet = p;
    done = 1'b0;
    n = 0;
    while (!done && n < 200) begin
      @(negedge clk);
      done = !edma_wait;
      @(posedge clk);
      #5;
      n++;
    end
    edma_access = 1'b0;
    if (!done) begin
      timeouts++;
      $display("timed out waiting for the DMA read to be accepted");
    end
  endtask

  task automatic send_cfg(input packet_t p);
    int n;
    logic done;
    ecfg_access = 1'b1;
    ecfg_packet = p;
    done = 1'b0;
    n = 0;
    while (!done && n < 200) begin
      @(negedge clk);
      done = !ecfg_wait;
      @(posedge clk);
      #5;
      n++;
    end
    ecfg_access = 1'b0;
    if (!done) begin
      timeouts++;
      $display("timed out waiting for the config packet to be accepted");
    end
  endtask

  task automatic issue_link(input packet_t p);
    predict_link(p);
    send_link(p);
  endtask

  task automatic program_mmu(input mmu_index_t idx, input link_id_t val);
    mmu_cfg_write = 1'b1;
    mmu_cfg_index = idx;
    mmu_cfg_value = val;
    tbl[idx] = val;
    @(posedge clk);
    #5;
    mmu_cfg_write = 1'b0;
  endtask

  // Let every expected packet come out
  task automatic drain();
    int n;
    n = 0;
    while ((wr_have || rd_have || rr_have) && n < 600) begin
      @(posedge clk);
      #5;
      n++;
    end
    if (wr_have || rd_have || rr_have) begin
      timeouts++;
      $display("timed out waiting for the output queues to drain");
    end
  endtask

  function automatic addr_t rr_addr();
    logic [31:0] r;
    r = rand_bits(16);
    return {link_id, 4'hD, r[15:0]};
  endfunction

  // ##############################
  // Stimulus
  // ##############################

  initial begin
    int n;
    packet_t p;
    erx_access = 1'b0;
    edma_access = 1'b0;
    ecfg_access = 1'b0;
    erx_packet = '0;
    edma_packet = '0;
    ecfg_packet = '0;
    mmu_enable = 1'b0;
    mmu_cfg_write = 1'b0;
    mmu_cfg_index = '0;
    mmu_cfg_value = '0;
    rxwr_wait = 1'b0;
    rxrd_wait = 1'b0;
    rxrr_wait = 1'b0;
    refresh_heads();
    @(posedge clk);
    n = 0;
    while (reset && n < 20) begin
      @(posedge clk);
      n++;
    end
    if (reset) begin
      timeouts++;
      $display("timed out waiting for reset to be released");
    end

    // Quiet outputs right after reset
    @(negedge clk);
    a_reset: assert (!rxwr_access && !rxrd_access && !rxrr_access && !rx_wr_wait
                     && !rx_rd_wait && !edma_wait && !ecfg_wait)
      else begin
        errors = errors + 1;
        $display("FAILED %0t: outputs not idle after reset", $time);
      end
    @(posedge clk);
    #5;

    // Translated writes, then untouched ones
    for (int i = 0; i < 16; i++) program_mmu(mmu_index_t'(i), link_id_t'(rand_bits(12)));
    mmu_enable = 1'b1;
    for (int i = 0; i < 6; i++) issue_link(make_packet(1'b1, rand_addr()));
    drain();
    mmu_enable = 1'b0;
    for (int i = 0; i < 4; i++) issue_link(make_packet(1'b1, rand_addr()));
    drain();

    // Link read racing a DMA read
    mmu_enable = 1'b1;
    issue_link(make_packet(1'b0, rand_addr()));
    p = make_packet(1'b0, rand_addr());
    push_rd(p);
    fork
      send_dma(p);
      begin
        @(negedge clk);
        a_dma_wait: assert (edma_wait)
          else begin
            errors = errors + 1;
            $display("FAILED %0t: edma_wait low beside an MMU read", $time);
          end
      end
    join
    issue_link(make_packet(1'b0, rand_addr()));
    // Answer all three reads
    for (int i = 0; i < 3; i++) issue_link(make_packet(1'b1, rr_addr()));
    drain();

    // Read response beside a config packet
    p = make_packet(1'b1, rr_addr());
    predict_link(p);
    ecfg_packet = make_packet(1'b1, rand_addr());
    push_rr(ecfg_packet);
    fork
      send_link(p);
      send_cfg(ecfg_packet);
      begin
        @(negedge clk);
        a_cfg_wait: assert (ecfg_wait)
          else begin
            errors = errors + 1;
            $display("FAILED %0t: ecfg_wait low beside a read response", $time);
          end
      end
    join
    drain();

    // Unanswered read gives one error response
    issue_link(make_packet(1'b0, rand_addr()));
    push_rr({32'h0, 32'hdeadbeef, link_id, 4'hF, 16'h0000, 8'h03});
    n = 0;
    while ((rd_have || rr_have) && n < 300) begin
      @(posedge clk);
      #5;
      n++;
    end
    if (rd_have || rr_have) begin
      timeouts++;
      $display("timed out waiting for the timeout response");
    end
    repeat (150) @(posedge clk);
    #5;
    // Answered read, no error response
    issue_link(make_packet(1'b0, rand_addr()));
    issue_link(make_packet(1'b1, rr_addr()));
    drain();
    repeat (150) @(posedge clk);
    #5;

    // Back-pressure on the write and response queues
    hold = 1'b1;
    fork
      for (int i = 0; i < 10; i++) issue_link(make_packet(1'b1, (i % 2 == 1) ? rr_addr() : rand_addr()));
      begin
        n = 0;
        while (!rx_wr_wait && n < 100) begin
          @(negedge clk);
          n++;
        end
        if (!rx_wr_wait) begin
          timeouts++;
          $display("timed out waiting for rx_wr_wait to rise");
        end
        repeat (20) @(posedge clk);
        @(negedge clk);
        a_stall: assert (rx_wr_wait)
          else begin
            errors = errors + 1;
            $display("FAILED %0t: rx_wr_wait dropped under back-pressure", $time);
          end
        @(posedge clk);
        #5;
        hold = 1'b0;
      end
    join
    drain();
    repeat (10) @(posedge clk);
    #5;

    $display("errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/tb_clock.sv
`default_nettype none

module tb_clock (
  output logic clk,
  output logic reset
);

  // 40 unit period
  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  // Held for the first 3 rising edges
  initial begin
    reset = 1'b1;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

`default_nettype wire

//--- rtl/erx_core.sv
`default_nettype none

module erx_core
  import erx_pkg::*;
#(
  parameter link_id_t link_id        = 12'h800,
  parameter int       fifo_depth     = 4,
  parameter int       timeout_cycles = 64
) (
  input  wire logic       clk,
  input  wire logic       reset,
  // Link
  input  wire logic       erx_access,
  input  wire packet_t    erx_packet,
  output logic            rx_rd_wait,
  output logic            rx_wr_wait,
  // DMA
  input  wire logic       edma_access,
  input  wire packet_t    edma_packet,
  output logic            edma_wait,
  // Config
  input  wire logic       ecfg_access,
  input  wire packet_t    ecfg_packet,
  output logic            ecfg_wait,
  // MMU setup
  input  wire logic       mmu_enable,
  input  wire logic       mmu_cfg_write,
  input  wire mmu_index_t mmu_cfg_index,
  input  wire link_id_t   mmu_cfg_value,
  // Queue outputs
  output logic            rxwr_access,
  output packet_t         rxwr_packet,
  input  wire logic       rxwr_wait,
  output logic            rxrd_access,
  output packet_t         rxrd_packet,
  input  wire logic       rxrd_wait,
  output logic            rxrr_access,
  output packet_t         rxrr_packet,
  input  wire logic       rxrr_wait
);

  // Arbiter to MMU and back
  logic    mmu_in_access;
  packet_t mmu_in_packet;
  logic    mmu_in_wait;
  logic    emmu_access;
  packet_t emmu_packet;
  logic    emmu_wait;

  // Watchdog handshake
  logic    timeout;
  logic    timeout_taken;
  logic    rd_issue;
  logic    rsp_seen;

  // Arbiter to FIFOs
  logic    wr_push_access;
  packet_t wr_push_packet;
  logic    wr_push_wait;
  logic    rd_push_access;
  packet_t rd_push_packet;
  logic    rd_push_wait;
  logic    rr_push_access;
  packet_t rr_push_packet;
  logic    rr_push_wait;

  // ##############################
  // Routing
  // ##############################

  erx_arbiter #(
    .link_id (link_id)
  ) i_arbiter (
    .erx_access    (erx_access),
    .erx_packet    (erx_packet),
    .rx_rd_wait    (rx_rd_wait),
    .rx_wr_wait    (rx_wr_wait),
    .mmu_in_access (mmu_in_access),
    .mmu_in_packet (mmu_in_packet),
    .mmu_in_wait   (mmu_in_wait),
    .emmu_access   (emmu_access),
    .emmu_packet   (emmu_packet),
    .emmu_wait     (emmu_wait),
    .edma_access   (edma_access),
    .edma_packet   (edma_packet),
    .edma_wait     (edma_wait),
    .ecfg_access   (ecfg_access),
    .ecfg_packet   (ecfg_packet),
    .ecfg_wait     (ecfg_wait),
    .timeout       (timeout),
    .timeout_taken (timeout_taken),
    .rd_issue      (rd_issue),
    .rsp_seen      (rsp_seen),
    .rxwr_access   (wr_push_access),
    .rxwr_packet   (wr_push_packet),
    .rxwr_wait     (wr_push_wait),
    .rxrd_access   (rd_push_access),
    .rxrd_packet   (rd_push_packet),
    .rxrd_wait     (rd_push_wait),
    .rxrr_access   (rr_push_access),
    .rxrr_packet   (rr_push_packet),
    .rxrr_wait     (rr_push_wait)
  );

  // Address translation, one cycle
  erx_mmu i_mmu (
    .clk        (clk),
    .reset      (reset),
    .enable     (mmu_enable),
    .cfg_write  (mmu_cfg_write),
    .cfg_index  (mmu_cfg_index),
    .cfg_value  (mmu_cfg_value),
    .in_access  (mmu_in_access),
    .in_packet  (mmu_in_packet),
    .in_wait    (mmu_in_wait),
    .out_access (emmu_access),
    .out_packet (emmu_packet),
    .out_wait   (emmu_wait)
  );

  erx_timeout #(
    .timeout_cycles (timeout_cycles)
  ) i_timeout (
    .clk           (clk),
    .reset         (reset),
    .rd_issue      (rd_issue),
    .rsp_seen      (rsp_seen),
    .timeout       (timeout),
    .timeout_taken (timeout_taken)
  );

  // ##############################
  // Output queues
  // ##############################

  erx_fifo #(.fifo_depth(fifo_depth)) i_wr_fifo (
    .clk        (clk),
    .reset      (reset),
    .in_access  (wr_push_access),
    .in_packet  (wr_push_packet),
    .in_wait    (wr_push_wait),
    .out_access (rxwr_access),
    .out_packet (rxwr_packet),
    .out_wait   (rxwr_wait)
  );

  erx_fifo #(.fifo_depth(fifo_depth)) i_rd_fifo (
    .clk        (clk),
    .reset      (reset),
    .in_access  (rd_push_access),
    .in_packet  (rd_push_packet),
    .in_wait    (rd_push_wait),
    .out_access (rxrd_access),
    .out_packet (rxrd_packet),
    .out_wait   (rxrd_wait)
  );

  erx_fifo #(.fifo_depth(fifo_depth)) i_rr_fifo (
    .clk        (clk),
    .reset      (reset),
    .in_access  (rr_push_access),
    .in_packet  (rr_push_packet),
    .in_wait    (rr_push_wait),
    .out_access (rxrr_access),
    .out_packet (rxrr_packet),
    .out_wait   (rxrr_wait)
  );

endmodule

`default_nettype wire

//--- rtl/erx_timeout.sv
`default_nettype none

module erx_timeout
  import erx_pkg::*;
#(
  parameter int timeout_cycles = 64
) (
  input  wire logic clk,
  input  wire logic reset,
  input  wire logic rd_issue,
  input  wire logic rsp_seen,
  output logic      timeout,
  input  wire logic timeout_taken
);

  localparam int timer_w = $clog2(timeout_cycles + 1);
  localparam int outst_w = 8;

  timeout_state_t     state_q;
  timeout_state_t     state_d;
  logic [outst_w-1:0] outstanding_q;
  logic [outst_w-1:0] outstanding_d;
  logic [timer_w-1:0] timer_q;
  logic [timer_w-1:0] timer_d;
  logic               answered;

  // Stray responses with nothing pending are ignored
  assign answered      = (rsp_seen | timeout_taken) & ((outstanding_q != '0) | rd_issue);
  assign outstanding_d = outstanding_q + outst_w'(rd_issue) - outst_w'(answered);

  // ##############################
  // Watchdog FSM
  // ##############################

  always_comb begin
    state_d = state_q;
    timer_d = timer_q + 1'b1;
    case (state_q)
      idle: begin
        timer_d = '0;
        if (outstanding_d != '0) begin
          state_d = counting;
        end
      end
      counting: begin
        if (outstanding_d == '0) begin
          state_d = idle;
          timer_d = '0;
        end else if (rsp_seen) begin
          // Any response restarts the wait
          timer_d = '0;
        end else if (timer_q == timer_w'(timeout_cycles - 1)) begin
          state_d = flagged;
          timer_d = '0;
        end
      end
      flagged: begin
        timer_d = '0;
        // Taken timeout retires one read
        if (timeout_taken) begin
          state_d = (outstanding_d != '0) ? counting : idle;
        end
      end
      default: begin
        state_d = idle;
        timer_d = '0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q       <= idle;
      outstanding_q <= '0;
      timer_q       <= '0;
    end else begin
      state_q       <= state_d;
      outstanding_q <= outstanding_d;
      timer_q       <= timer_d;
    end
  end

  assign timeout = (state_q == flagged);

  // A raised timeout always has an open read left to retire
  a_no_underflow: assert property (@(posedge clk) disable iff (reset)
    timeout |-> outstanding_q != '0);

  // Arbiter only takes a raised timeout
  a_taken_valid: assert property (@(posedge clk) disable iff (reset)
    timeout_taken |-> timeout);

endmodule

`default_nettype wire

//--- rtl/erx_arbiter.sv
`default_nettype none

module erx_arbiter
  import erx_pkg::*;
#(
  parameter link_id_t link_id = 12'h800
) (
  // Link side
  input  wire logic    erx_access,
  input  wire packet_t erx_packet,
  output logic         rx_rd_wait,
  output logic         rx_wr_wait,
  // Into the MMU
  output logic         mmu_in_access,
  output packet_t      mmu_in_packet,
  input  wire logic    mmu_in_wait,
  // Back from the MMU
  input  wire logic    emmu_access,
  input  wire packet_t emmu_packet,
  output logic         emmu_wait,
  // DMA reads
  input  wire logic    edma_access,
  input  wire packet_t edma_packet,
  output logic         edma_wait,
  // Config responses
  input  wire logic    ecfg_access,
  input  wire packet_t ecfg_packet,
  output logic         ecfg_wait,
  // Timeout circuit
  input  wire logic    timeout,
  output logic         timeout_taken,
  output logic         rd_issue,
  output logic         rsp_seen,
  // Write queue
  output logic         rxwr_access,
  output packet_t      rxwr_packet,
  input  wire logic    rxwr_wait,
  // Read queue
  output logic         rxrd_access,
  output packet_t      rxrd_packet,
  input  wire logic    rxrd_wait,
  // Read response queue
  output logic         rxrr_access,
  output packet_t      rxrr_packet,
  input  wire logic    rxrr_wait
);

  addr_t   erx_dstaddr;
  logic    erx_rr;
  logic    emmu_write;
  logic    emmu_read;
  packet_t timeout_packet;

  // ##############################
  // Read response check
  // ##############################

  assign erx_dstaddr = pkt_dstaddr(erx_packet);
  // Write back to our own id in the D region
  assign erx_rr = erx_access & pkt_write(erx_packet)
                & (erx_dstaddr[id_lsb +: $bits(link_id_t)] == link_id)
                & (erx_dstaddr[region_lsb +: 4] == rr_region);

  // Everything else gets translated
  assign mmu_in_access = erx_access & ~erx_rr;
  assign mmu_in_packet = erx_packet;

  // ##############################
  // Write and read queues
  // ##############################

  assign emmu_write  = emmu_access & pkt_write(emmu_packet);
  assign emmu_read   = emmu_access & ~pkt_write(emmu_packet);

  assign rxwr_access = emmu_write;
  assign rxwr_packet = emmu_packet;

  // MMU read beats DMA
  assign rxrd_access = emmu_read | edma_access;
  assign rxrd_packet = emmu_read ? emmu_packet : edma_packet;

  // Stall the MMU on whichever queue it targets
  assign emmu_wait = (emmu_write & rxwr_wait) | (emmu_read & rxrd_wait);
  assign edma_wait = rxrd_wait | emmu_read;

  // ##############################
  // Read response queue
  // ##############################

  // Error response, srcaddr zero
  assign timeout_packet = {addr_t'(0), timeout_data, link_id, timeout_region,
                           16'h0000, timeout_low_byte};

  // Timeout, then link, then config
  assign rxrr_access = timeout | erx_rr | ecfg_access;
  assign rxrr_packet = timeout ? timeout_packet :
                       erx_rr  ? erx_packet     :
                                 ecfg_packet;

  assign ecfg_wait = timeout | erx_rr | rxrr_wait;

  // Waits seen by the link, per path
  assign rx_wr_wait = erx_rr ? (rxrr_wait | timeout) : mmu_in_wait;
  assign rx_rd_wait = rxrd_wait;

  // Events for the watchdog
  assign timeout_taken = timeout & ~rxrr_wait;
  assign rsp_seen      = erx_rr & ~timeout & ~rxrr_wait;
  assign rd_issue      = rxrd_access & ~rxrd_wait;

  // At most one source gets through per shared queue
  always_comb begin
    a_one_source: assert ($onehot0({emmu_read & ~emmu_wait, edma_access & ~edma_wait})
                          && $onehot0({timeout_taken, rsp_seen,
                                       ecfg_access & ~ecfg_wait}));
  end

endmodule

`default_nettype wire

//--- rtl/erx_mmu.sv
`default_nettype none

module erx_mmu
  import erx_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       reset,
  input  wire logic       enable,
  // Table programming
  input  wire logic       cfg_write,
  input  wire mmu_index_t cfg_index,
  input  wire link_id_t   cfg_value,
  // Untranslated packets
  input  wire logic       in_access,
  input  wire packet_t    in_packet,
  output logic            in_wait,
  // Translated packets
  output logic            out_access,
  output packet_t         out_packet,
  input  wire logic       out_wait
);

  link_id_t   table_q [16];
  logic       out_valid_q;
  packet_t    out_packet_q;
  addr_t      in_dstaddr;
  mmu_index_t in_index;
  addr_t      mapped_dstaddr;
  logic       load;

  // ##############################
  // Lookup
  // ##############################

  assign in_dstaddr = pkt_dstaddr(in_packet);
  // Top nibble picks the entry
  assign in_index   = in_dstaddr[index_lsb +: $bits(mmu_index_t)];
  // New link id on top, low 20 bits kept
  assign mapped_dstaddr = {table_q[in_index], in_dstaddr[id_lsb-1:0]};

  // Table write port
  always_ff @(posedge clk) begin
    if (cfg_write) begin
      table_q[cfg_index] <= cfg_value;
    end
  end

  // ##############################
  // Output stage
  // ##############################

  // Stall only while holding a stuck packet
  assign in_wait = out_valid_q & out_wait;
  assign load    = in_access & ~in_wait;

  // Refill in the cycle the held packet leaves
  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid_q <= 1'b0;
    end else if (!in_wait) begin
      out_valid_q <= in_access;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      if (enable) begin
        out_packet_q <= pkt_set_dstaddr(in_packet, mapped_dstaddr);
      end else begin
        // Bypass, address untouched
        out_packet_q <= in_packet;
      end
    end
  end

  assign out_access = out_valid_q;
  assign out_packet = out_packet_q;

  // Held output survives a stall
  a_hold: assert property (@(posedge clk) disable iff (reset)
    out_access && out_wait |=> out_access && $stable(out_packet));

endmodule

`default_nettype wire

//--- rtl/erx_fifo.sv
`default_nettype none

module erx_fifo
  import erx_pkg::*;
#(
  parameter int fifo_depth = 4
) (
  input  wire logic    clk,
  input  wire logic    reset,
  input  wire logic    in_access,
  input  wire packet_t in_packet,
  output logic         in_wait,
  output logic         out_access,
  output packet_t      out_packet,
  input  wire logic    out_wait
);

  localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
  localparam int cnt_w = $clog2(fifo_depth + 1);

  packet_t          mem [fifo_depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             full;
  logic             push;
  logic             pop;

  // Wrap at depth, not at a power of two
  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    return (ptr == ptr_w'(fifo_depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full       = (count == cnt_w'(fifo_depth));
  assign push       = in_access & ~full;
  assign pop        = out_access & ~out_wait;
  // Back-pressure only when full
  assign in_wait    = full;
  // Head entry always on the output
  assign out_access = (count != '0);
  assign out_packet = mem[rd_ptr];

  // Storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_packet;
    end
  end

  // Pointers and fill level
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Level stays within depth, pointers meet only when empty or full
  a_no_overflow: assert property (@(posedge clk) disable iff (reset)
    count <= cnt_w'(fifo_depth) && ((wr_ptr == rd_ptr) == (count == '0 || full)));

  // Stalled head stays put for the consumer
  a_out_stable: assert property (@(posedge clk) disable iff (reset)
    out_access && out_wait |=> out_access && $stable(out_packet));

endmodule

`default_nettype wire

//--- rtl/erx_pkg.sv
`default_nettype none

package erx_pkg;

  // ##############################
  // Packet layout
  // ##############################

  // Emesh packet width
  localparam int pkt_w = 104;

  // Field positions, counted from bit 0
  localparam int write_pos   = 0;
  localparam int dstaddr_lsb = 8;

  // Address sub-fields
  localparam int id_lsb     = 20;
  localparam int index_lsb  = 28;
  localparam int region_lsb = 16;

  typedef logic [pkt_w-1:0] packet_t;
  typedef logic [31:0]      addr_t;
  typedef logic [11:0]      link_id_t;
  typedef logic [3:0]       mmu_index_t;

  // Nibble marking a read response
  localparam logic [3:0] rr_region = 4'hD;

  // Timeout error response fields
  localparam logic [31:0] timeout_data     = 32'hdeadbeef;
  localparam logic [3:0]  timeout_region   = 4'hF;
  // Write, datamode 01
  localparam logic [7:0]  timeout_low_byte = 8'h03;

  // Timeout watchdog FSM
  typedef enum logic [1:0] {
    idle,
    counting,
    flagged
  } timeout_state_t;

  // ##############################
  // Field access
  // ##############################

  function automatic logic pkt_write(input packet_t pkt);
    return pkt[write_pos];
  endfunction

  function automatic addr_t pkt_dstaddr(input packet_t pkt);
    return pkt[dstaddr_lsb +: $bits(addr_t)];
  endfunction

  // Same packet, new destination
  function automatic packet_t pkt_set_dstaddr(input packet_t pkt, input addr_t addr);
    packet_t result;
    result = pkt;
    result[dstaddr_lsb +: $bits(addr_t)] = addr;
    return result;
  endfunction

endpackage

`default_nettype wire
